// File: source/icache_store_pkg.sv
// Shared geometry, key widths and types for the scrambled instruction cache store.
// Modules take what they need by a wildcard import in their header.

`default_nettype none

package icache_store_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Cache geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned IC_NUM_LINES = 16;
  localparam int unsigned IC_INDEX_W   = $clog2(IC_NUM_LINES);
  localparam int unsigned IC_OFFSET_W  = 2;
  localparam int unsigned IC_TAG_W     = 32 - IC_INDEX_W - IC_OFFSET_W;
  localparam int unsigned IC_DATA_W    = 32;

  ////////////////////////////////////////////////////////////////////////////
  // Scrambling
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned SCRAMBLE_KEY_W   = 64;
  localparam int unsigned SCRAMBLE_NONCE_W = 32;

  // Key in use out of reset, before the key manager has delivered one
  localparam logic [SCRAMBLE_KEY_W-1:0]   RND_CNST_KEY   = 64'h3b9c_e17d_52a0_864f;
  localparam logic [SCRAMBLE_NONCE_W-1:0] RND_CNST_NONCE = 32'hd4e2_0b79;

  // Fetch address, seen whole or split into its cache fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [IC_TAG_W-1:0]    tag;
      logic [IC_INDEX_W-1:0]  index;
      logic [IC_OFFSET_W-1:0] offset;
    } fields;
  } ic_addr_u;

  // Invalidation controller
  typedef enum logic [1:0] {
    ST_READY = 2'b00,
    ST_SWEEP = 2'b01,
    ST_REKEY = 2'b10
  } inval_state_e;

endpackage

`default_nettype wire

// File: source/icache_ram_if.sv
// Bank request channel from the invalidation controller to the tag and data banks.
// Each req is one full operation and is never stalled.

`timescale 1ns/1ps
`default_nettype none

interface icache_ram_if import icache_store_pkg::*; ();

  logic                  req;
  logic                  write;
  // Sweep write, drops the valid bit
  logic                  clear;
  logic [IC_INDEX_W-1:0] index;
  logic [IC_TAG_W-1:0]   tag;
  logic [IC_DATA_W-1:0]  wdata;

  modport ctrl (
    output req, write, clear, index, tag, wdata
  );

  modport bank (
    input req, write, clear, index, tag, wdata
  );

endinterface

`default_nettype wire

// File: source/icache_inval_fsm.sv
// Invalidation controller. Passes fills and lookups to the banks while ready,
// sweeps all valid bits on invalidation and requests a fresh scramble key.
// busy_o stays high until the sweep is done and a valid key is held.

`timescale 1ns/1ps
`default_nettype none

module icache_inval_fsm import icache_store_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic                  inval_i,
  input  logic                  fill_i,
  input  logic                  lookup_i,
  input  logic [IC_INDEX_W-1:0] fill_index_i,
  input  logic [IC_INDEX_W-1:0] lookup_index_i,
  input  logic [IC_TAG_W-1:0]   fill_tag_i,
  input  logic [IC_TAG_W-1:0]   lookup_tag_i,
  input  logic [IC_DATA_W-1:0]  fill_data_i,

  input  logic [IC_INDEX_W-1:0] sweep_index_i,
  input  logic                  sweep_done_i,
  input  logic                  key_valid_i,
  input  logic                  scramble_key_valid_i,

  output logic                  sweep_en_o,
  output logic                  scramble_req_o,
  output logic                  key_clear_o,
  output logic                  busy_o,

  icache_ram_if.ctrl            ram
);

  inval_state_e state_q, state_d;
  logic         scramble_req_q, scramble_req_d;
  logic         start_sweep;

  // Invalidation is only taken while idle
  assign start_sweep = (state_q == ST_READY) & inval_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_READY: begin
        if (inval_i) begin
          state_d = ST_SWEEP;
        end
      end
      ST_SWEEP: begin
        if (sweep_done_i) begin
          state_d = key_valid_i ? ST_READY : ST_REKEY;
        end
      end
      ST_REKEY: begin
        if (key_valid_i) begin
          state_d = ST_READY;
        end
      end
      default: state_d = ST_READY;
    endcase
  end

  // Request rises with the invalidation and holds until a key is seen
  assign scramble_req_d = scramble_req_q ? ~scramble_key_valid_i : start_sweep;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= ST_READY;
      scramble_req_q <= 1'b0;
    end else begin
      state_q        <= state_d;
      scramble_req_q <= scramble_req_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bank requests
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    ram.req   = 1'b0;
    ram.write = 1'b0;
    ram.clear = 1'b0;
    ram.index = lookup_index_i;
    ram.tag   = lookup_tag_i;
    ram.wdata = fill_data_i;
    if (state_q == ST_SWEEP) begin
      ram.req   = 1'b1;
      ram.write = 1'b1;
      ram.clear = 1'b1;
      ram.index = sweep_index_i;
      ram.tag   = '0;
    end else if (state_q == ST_READY) begin
      ram.req   = fill_i | lookup_i;
      ram.write = fill_i;
      if (fill_i) begin
        ram.index = fill_index_i;
        ram.tag   = fill_tag_i;
      end
    end
  end

  assign sweep_en_o     = (state_q == ST_SWEEP);
  assign busy_o         = (state_q != ST_READY);
  assign key_clear_o    = start_sweep;
  assign scramble_req_o = scramble_req_q;

endmodule

`default_nettype wire

// File: source/icache_sweep_counter.sv
// Line counter for the invalidation sweep. Steps one index per enabled cycle
// and flags the last line so the controller knows when the sweep ends.

`timescale 1ns/1ps
`default_nettype none

module icache_sweep_counter import icache_store_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  en_i,
  output logic [IC_INDEX_W-1:0] index_o,
  output logic                  done_o
);

  localparam logic [IC_INDEX_W-1:0] LastIndex = IC_INDEX_W'(IC_NUM_LINES - 1);

  logic [IC_INDEX_W-1:0] index_q;
  logic                  at_last;

  assign at_last = (index_q == LastIndex);

  // Wraps back to zero so the next sweep starts at line 0
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      index_q <= '0;
    end else if (en_i) begin
      index_q <= at_last ? '0 : index_q + 1'b1;
    end
  end

  assign index_o = index_q;
  assign done_o  = en_i & at_last;

endmodule

`default_nettype wire

// File: source/icache_key_reg.sv
// Scramble key and nonce store with its valid flag.
// Out of reset it holds the built-in key as valid. The per-line keystream is
// formed combinationally from nonce, key half and line index.

`timescale 1ns/1ps
`default_nettype none

module icache_key_reg import icache_store_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        key_clear_i,
  input  logic                        scramble_key_valid_i,
  input  logic [SCRAMBLE_KEY_W-1:0]   scramble_key_i,
  input  logic [SCRAMBLE_NONCE_W-1:0] scramble_nonce_i,
  input  logic [IC_INDEX_W-1:0]       index_i,
  output logic                        key_valid_o,
  output logic [IC_DATA_W-1:0]        keystream_o
);

  logic [SCRAMBLE_KEY_W-1:0]   key_q;
  logic [SCRAMBLE_NONCE_W-1:0] nonce_q;
  logic                        key_valid_q;
  logic [IC_DATA_W-1:0]        key_half;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q   <= RND_CNST_KEY;
      nonce_q <= RND_CNST_NONCE;
    end else if (scramble_key_valid_i) begin
      key_q   <= scramble_key_i;
      nonce_q <= scramble_nonce_i;
    end
  end

  // Invalidation drops the flag, a delivered key sets it again
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_valid_q <= 1'b1;
    end else if (key_clear_i) begin
      key_valid_q <= 1'b0;
    end else if (scramble_key_valid_i) begin
      key_valid_q <= 1'b1;
    end
  end

  // Odd lines use the upper key half
  assign key_half = index_i[0] ? key_q[SCRAMBLE_KEY_W-1:IC_DATA_W] : key_q[IC_DATA_W-1:0];

  assign keystream_o = nonce_q ^ key_half ^ {(IC_DATA_W / IC_INDEX_W){index_i}};
  assign key_valid_o = key_valid_q;

endmodule

`default_nettype wire

// File: source/icache_tag_bank.sv
// Valid bits and tags, one entry per line, with a registered hit result.
// A read compares the stored tag against the request tag; a clear drops the
// valid bit of its line.

`timescale 1ns/1ps
`default_nettype none

module icache_tag_bank import icache_store_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  icache_ram_if.bank ram,
  output logic       rvalid_o,
  output logic       hit_o
);

  logic [IC_NUM_LINES-1:0] valid_q;
  logic [IC_TAG_W-1:0]     tag_mem [IC_NUM_LINES];
  logic                    rvalid_q;
  logic                    hit_q;
  logic                    rd_en;
  logic                    fill_en;

  assign rd_en   = ram.req & ~ram.write;
  assign fill_en = ram.req & ram.write & ~ram.clear;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      rvalid_q <= 1'b0;
      hit_q    <= 1'b0;
    end else begin
      rvalid_q <= rd_en;
      if (ram.req && ram.write) begin
        valid_q[ram.index] <= ~ram.clear;
      end
      if (rd_en) begin
        hit_q <= valid_q[ram.index] & (tag_mem[ram.index] == ram.tag);
      end
    end
  end

  // Tag storage
  always_ff @(posedge clk_i) begin
    if (fill_en) begin
      tag_mem[ram.index] <= ram.tag;
    end
  end

  assign rvalid_o = rvalid_q;
  assign hit_o    = hit_q;

endmodule

`default_nettype wire

// File: source/icache_data_bank.sv
// Scrambled line data store. Fill data is XORed with the keystream of its line
// on the way in, and read data XORed again on the way out, one cycle after
// the request. Sweep clears leave the data untouched.

`timescale 1ns/1ps
`default_nettype none

module icache_data_bank import icache_store_pkg::*; (
  input  logic                 clk_i,
  input  logic [IC_DATA_W-1:0] keystream_i,
  icache_ram_if.bank           ram,
  output logic [IC_DATA_W-1:0] rdata_o
);

  logic [IC_DATA_W-1:0] data_mem [IC_NUM_LINES];
  logic [IC_DATA_W-1:0] rdata_q;
  logic                 wr_en;
  logic                 rd_en;

  assign wr_en = ram.req & ram.write & ~ram.clear;
  assign rd_en = ram.req & ~ram.write;

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      data_mem[ram.index] <= ram.wdata ^ keystream_i;
    end
  end

  // Descramble with the keystream of the same line
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= data_mem[ram.index] ^ keystream_i;
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: source/icache_store_top.sv
// Top level of the scrambled instruction cache store.
// Splits fill and lookup addresses into cache fields and connects the
// controller, sweep counter, key register and the two banks.

`timescale 1ns/1ps
`default_nettype none

module icache_store_top import icache_store_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  input  logic                        inval_i,
  input  logic                        fill_i,
  input  logic [31:0]                 fill_addr_i,
  input  logic [IC_DATA_W-1:0]        fill_data_i,
  input  logic                        lookup_i,
  input  logic [31:0]                 lookup_addr_i,

  input  logic                        scramble_key_valid_i,
  input  logic [SCRAMBLE_KEY_W-1:0]   scramble_key_i,
  input  logic [SCRAMBLE_NONCE_W-1:0] scramble_nonce_i,

  output logic                        rvalid_o,
  output logic                        hit_o,
  output logic [IC_DATA_W-1:0]        rdata_o,
  output logic                        busy_o,
  output logic                        scramble_req_o
);

  ic_addr_u              fill_addr;
  ic_addr_u              lookup_addr;
  logic                  sweep_en;
  logic                  sweep_done;
  logic [IC_INDEX_W-1:0] sweep_index;
  logic                  key_clear;
  logic                  key_valid;
  logic [IC_DATA_W-1:0]  keystream;

  icache_ram_if ram_if ();

  assign fill_addr.raw   = fill_addr_i;
  assign lookup_addr.raw = lookup_addr_i;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  icache_inval_fsm u_inval_fsm (
    .clk_i,
    .rst_ni,
    .inval_i,
    .fill_i,
    .lookup_i,
    .fill_index_i        (fill_addr.fields.index),
    .lookup_index_i      (lookup_addr.fields.index),
    .fill_tag_i          (fill_addr.fields.tag),
    .lookup_tag_i        (lookup_addr.fields.tag),
    .fill_data_i,
    .sweep_index_i       (sweep_index),
    .sweep_done_i        (sweep_done),
    .key_valid_i         (key_valid),
    .scramble_key_valid_i,
    .sweep_en_o          (sweep_en),
    .scramble_req_o,
    .key_clear_o         (key_clear),
    .busy_o,
    .ram                 (ram_if)
  );

  icache_sweep_counter u_sweep_counter (
    .clk_i,
    .rst_ni,
    .en_i    (sweep_en),
    .index_o (sweep_index),
    .done_o  (sweep_done)
  );

  // Keystream follows the line addressed on the bank channel
  icache_key_reg u_key_reg (
    .clk_i,
    .rst_ni,
    .key_clear_i (key_clear),
    .scramble_key_valid_i,
    .scramble_key_i,
    .scramble_nonce_i,
    .index_i     (ram_if.index),
    .key_valid_o (key_valid),
    .keystream_o (keystream)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Banks
  ////////////////////////////////////////////////////////////////////////////

  icache_tag_bank u_tag_bank (
    .clk_i,
    .rst_ni,
    .ram      (ram_if),
    .rvalid_o,
    .hit_o
  );

  icache_data_bank u_data_bank (
    .clk_i,
    .keystream_i (keystream),
    .ram         (ram_if),
    .rdata_o
  );

endmodule

`default_nettype wire

// File: verif/icache_store_tb.sv
// Testbench for the scrambled instruction cache store. Random fills and lookups
// are checked against a line model, along with invalidation and rekey timing.

`timescale 1ns/1ps
`default_nettype none

module icache_store_tb import icache_store_pkg::*; ();

  localparam int NUM_OPS      = 200;
  localparam int MAX_KEY_WAIT = 2 * IC_NUM_LINES;
  // Two cycles per operation plus both invalidations
  localparam int WATCHDOG_CYCLES = 2 * (2 * NUM_OPS + 4 * IC_NUM_LINES)
                                 + 2 * (IC_NUM_LINES + MAX_KEY_WAIT + 8) + 20;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        inval_i, fill_i, lookup_i, scramble_key_valid_i;
  logic [31:0]                 fill_addr_i, lookup_addr_i;
  logic [IC_DATA_W-1:0]        fill_data_i, rdata_o;
  logic [SCRAMBLE_KEY_W-1:0]   scramble_key_i;
  logic [SCRAMBLE_NONCE_W-1:0] scramble_nonce_i;
  logic                        rvalid_o, hit_o, busy_o, scramble_req_o;

  // Line model and the lookup in flight
  logic [IC_NUM_LINES-1:0] model_valid;
  logic [IC_TAG_W-1:0]     model_tag [IC_NUM_LINES];
  logic [IC_DATA_W-1:0]    model_data [IC_NUM_LINES];
  logic [IC_TAG_W-1:0]     tag_pool [4];
  logic                    pend_lookup, pend_hit;
  logic [31:0]             pend_addr;
  logic [IC_DATA_W-1:0]    pend_data;
  ic_addr_u                addr;

  integer seed = 32'h492b6c4c;
  int     cycle, errors, checks, tests, test_errors, busy_cycles;
  string  test_name;

  always #20 clk_i = ~clk_i;

  icache_store_top u_dut (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_error(input string msg);
    errors++;
    $display("error in %s: %s", test_name, msg);
  endtask

  task automatic check_hit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch in %s, %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic check_data(input string what, input logic [IC_DATA_W-1:0] exp,
                            input logic [IC_DATA_W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch in %s, %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch in %s, %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = errors;
  endtask

  task automatic finish_test();
    tests++;
    $display("%-18s %s, %0d errors", test_name,
             (errors == test_errors) ? "passed" : "failed", errors - test_errors);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Tags come from a small pool so lines hit and conflict often
  function automatic ic_addr_u rand_addr();
    ic_addr_u    a;
    logic [31:0] r;
    r = $random(seed);
    a.fields.tag    = tag_pool[r[1:0]];
    a.fields.index  = r[IC_INDEX_W+1:2];
    a.fields.offset = r[IC_OFFSET_W+IC_INDEX_W+1:IC_INDEX_W+2];
    return a;
  endfunction

  // Advance one cycle, check the lookup in flight, release the strobes
  task automatic step();
    @(posedge clk_i);
    #2;
    cycle++;
    if (pend_lookup) begin
      if (rvalid_o !== 1'b1) begin
        report_error($sformatf("rvalid_o did not rise after the lookup of %h", pend_addr));
      end else begin
        check_hit($sformatf("hit_o for %h", pend_addr), pend_hit, hit_o);
        if (pend_hit) begin
          check_data($sformatf("rdata_o for %h", pend_addr), pend_data, rdata_o);
        end
      end
    end else if (rvalid_o !== 1'b0) begin
      report_error("rvalid_o is high with no lookup in flight");
    end
    pend_lookup          = 1'b0;
    inval_i              = 1'b0;
    fill_i               = 1'b0;
    lookup_i             = 1'b0;
    scramble_key_valid_i = 1'b0;
  endtask

  task automatic do_fill(input ic_addr_u a, input logic [IC_DATA_W-1:0] d);
    fill_i      = 1'b1;
    fill_addr_i = a.raw;
    fill_data_i = d;
    model_valid[a.fields.index] = 1'b1;
    model_tag[a.fields.index]   = a.fields.tag;
    model_data[a.fields.index]  = d;
    step();
  endtask

  task automatic do_lookup(input ic_addr_u a);
    lookup_i      = 1'b1;
    lookup_addr_i = a.raw;
    pend_lookup   = 1'b1;
    pend_addr     = a.raw;
    pend_hit      = model_valid[a.fields.index] &&
                    (model_tag[a.fields.index] == a.fields.tag);
    pend_data     = model_data[a.fields.index];
    step();
  endtask

  task automatic random_traffic(input int n);
    logic [31:0] r;
    repeat (n) begin
      r = $random(seed);
      if (r[0]) begin
        do_fill(rand_addr(), $random(seed));
      end else begin
        do_lookup(rand_addr());
      end
    end
  endtask

  // Invalidate, deliver a key key_wait cycles later, wait for busy_o to drop
  task automatic invalidate(input int key_wait);
    int start;
    start   = cycle;
    inval_i = 1'b1;
    step();
    model_valid = '0;
    check_flag("busy_o after inval_i", 1'b1, busy_o);
    check_flag("scramble_req_o after inval_i", 1'b1, scramble_req_o);
    repeat (key_wait - 1) step();
    check_flag("busy_o before the key", 1'b1, busy_o);
    check_flag("scramble_req_o before the key", 1'b1, scramble_req_o);
    scramble_key_valid_i = 1'b1;
    scramble_key_i       = {$random(seed), $random(seed)};
    scramble_nonce_i     = $random(seed);
    step();
    check_flag("scramble_req_o after the key", 1'b0, scramble_req_o);
    while (busy_o === 1'b1 && cycle - start <= IC_NUM_LINES + key_wait + 4) begin
      step();
    end
    if (busy_o !== 1'b0) begin
      report_error("busy_o did not fall after the sweep and the new key");
    end
    busy_cycles = cycle - start - 1;
  endtask

  initial begin
    clk_i                = 1'b0;
    rst_ni               = 1'b0;
    inval_i              = 1'b0;
    fill_i               = 1'b0;
    lookup_i             = 1'b0;
    scramble_key_valid_i = 1'b0;
    fill_addr_i          = '0;
    lookup_addr_i        = '0;
    fill_data_i          = '0;
    scramble_key_i       = '0;
    scramble_nonce_i     = '0;
    pend_lookup          = 1'b0;
    model_valid          = '0;
    for (int i = 0; i < 4; i++) begin
      tag_pool[i] = IC_TAG_W'($random(seed));
    end
    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    start_test("reset_state");
    check_flag("busy_o", 1'b0, busy_o);
    check_flag("scramble_req_o", 1'b0, scramble_req_o);
    check_flag("rvalid_o", 1'b0, rvalid_o);
    repeat (IC_NUM_LINES) do_lookup(rand_addr());
    finish_test();

    start_test("random_traffic");
    random_traffic(NUM_OPS);
    finish_test();

    // Key arrives after the sweep has ended
    start_test("inval_rekey");
    invalidate(IC_NUM_LINES + ($random(seed) & 15));
    finish_test();

    start_test("cleared_readback");
    for (int i = 0; i < IC_NUM_LINES; i++) begin
      addr = rand_addr();
      addr.fields.index = IC_INDEX_W'(i);
      do_lookup(addr);
    end
    for (int i = 0; i < IC_NUM_LINES; i++) begin
      addr = rand_addr();
      addr.fields.index = IC_INDEX_W'(i);
      do_fill(addr, $random(seed));
      do_lookup(addr);
    end
    finish_test();

    start_test("early_key");
    invalidate(2 + ($random(seed) & 7));
    if (busy_cycles != IC_NUM_LINES) begin
      errors++;
      $display("mismatch in %s, busy_o cycles: expected %0d, actual %0d",
               test_name, IC_NUM_LINES, busy_cycles);
    end
    random_traffic(NUM_OPS);
    finish_test();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: icache_store.f
source/icache_store_pkg.sv
source/icache_ram_if.sv
source/icache_inval_fsm.sv
source/icache_sweep_counter.sv
source/icache_key_reg.sv
source/icache_tag_bank.sv
source/icache_data_bank.sv
source/icache_store_top.sv
verif/icache_store_tb.sv

// File: Makefile
TOP := icache_store_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): icache_store.f $(wildcard source/*.sv verif/*.sv)
	verilator --binary --timing -j 0 -f icache_store.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

lint:
	verilator --lint-only --timing -Wall -f icache_store.f --top-module icache_store_top

clean:
	rm -rf obj_dir
